// File: Makefile
.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert -j 0 -f flist.f \
		--top-module backend_tb -Mdir obj_dir -o backend_sim
	./obj_dir/backend_sim | tee sim.log
	grep -q "PASS: all tests" sim.log

lint:
	verilator --lint-only --timing -f flist.f --top-module backend_tb

clean:
	rm -rf obj_dir sim.log

// File: flist.f
+incdir+logic
logic/backend_pkg.sv
logic/backend_if.sv
logic/issue_unit.sv
logic/ex_stage.sv
logic/mul_unit.sv
logic/commit_regfile.sv
logic/int_backend.sv
verification/backend_tb.sv

// File: logic/backend_if.sv
`timescale 1ns/100ps

`include "backend_settings.svh"

// One link of the execute chain
interface stage_if import backend_pkg::*; ();

    logic               valid;
    logic               ready;
    fu_e                sel;
    logic [`REG_AW-1:0] rd;
    logic [`XLEN-1:0]   data;
    logic               done;

    modport up (
        output valid, sel, rd, data, done,
        input  ready
    );

    modport down (
        input  valid, sel, rd, data, done,
        output ready
    );

endinterface

// Multiplier request and response
interface mul_if ();

    logic             req_valid;
    logic             req_ready;
    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    logic             resp_valid;
    logic [`XLEN-1:0] resp_data;

    modport req (
        output req_valid, a, b,
        input  req_ready
    );

    modport unit (
        input  req_valid, a, b,
        output req_ready, resp_valid, resp_data
    );

endinterface

// File: logic/backend_pkg.sv
`include "backend_settings.svh"

package backend_pkg;

    // Operation codes seen at the backend input
    typedef enum logic [2:0] {
        OP_ADD  = 3'd0,
        OP_SUB  = 3'd1,
        OP_AND  = 3'd2,
        OP_OR   = 3'd3,
        OP_XOR  = 3'd4,
        OP_ADDI = 3'd5,
        OP_MUL  = 3'd6
    } op_e;

    // Where a stage's result comes from
    typedef enum logic {
        FU_ALU = 1'b0,
        FU_MUL = 1'b1
    } fu_e;

    // What a stage exposes to the forwarding logic
    typedef struct packed {
        logic               pending;
        logic [`REG_AW-1:0] rd;
        logic               done;
        logic [`XLEN-1:0]   data;
    } byp_t;

endpackage

// File: logic/backend_settings.svh
`ifndef BACKEND_SETTINGS_SVH
`define BACKEND_SETTINGS_SVH

// Datapath and register file geometry
`define XLEN       32
`define NUM_REGS   16
`define REG_AW     4

// Number of execute stages between issue and commit
`define EX_DEPTH   2

// Shift-add multiplier retires one multiplier bit per cycle
`define MUL_CYCLES `XLEN

`endif

// File: logic/commit_regfile.sv
`timescale 1ns/100ps

`include "backend_settings.svh"

module commit_regfile import backend_pkg::*; (
    input  logic               clk_i,
    input  logic               rst_ni,

    input  logic [`REG_AW-1:0] rs1_addr_i,
    input  logic [`REG_AW-1:0] rs2_addr_i,
    output logic [`XLEN-1:0]   rs1_data_o,
    output logic [`XLEN-1:0]   rs2_data_o,

    output logic               commit_valid_o,
    output logic [`REG_AW-1:0] commit_rd_o,
    output logic [`XLEN-1:0]   commit_data_o,

    stage_if.down              wb_in
);

    logic [`XLEN-1:0] regs_q [`NUM_REGS];
    logic             we;

    // Only finished results leave the last stage
    assign wb_in.ready = wb_in.done;
    assign we          = wb_in.valid && wb_in.done;

    assign commit_valid_o = we;
    assign commit_rd_o    = wb_in.rd;
    assign commit_data_o  = wb_in.data;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we && wb_in.rd != '0) begin
            regs_q[wb_in.rd] <= wb_in.data;
        end
    end

    // Registered reads see a write from the same cycle
    always_ff @(posedge clk_i) begin
        rs1_data_o <= (we && wb_in.rd != '0 && wb_in.rd == rs1_addr_i) ?
                      wb_in.data : regs_q[rs1_addr_i];
        rs2_data_o <= (we && wb_in.rd != '0 && wb_in.rd == rs2_addr_i) ?
                      wb_in.data : regs_q[rs2_addr_i];
    end

endmodule

// File: logic/ex_stage.sv
`timescale 1ns/100ps

`include "backend_settings.svh"

module ex_stage import backend_pkg::*; (
    input  logic             clk_i,
    input  logic             rst_ni,

    // Multiplier response, shared by every stage
    input  logic             mul_valid_i,
    input  logic [`XLEN-1:0] mul_data_i,

    output byp_t             byp_o,

    stage_if.down            in_if,
    stage_if.up              out_if
);

    logic               pending_q;
    fu_e                sel_q;
    logic               done_q;
    logic [`REG_AW-1:0] rd_q;
    logic [`XLEN-1:0]   data_q;

    logic             done_now;
    logic [`XLEN-1:0] data_now;
    logic             in_fire;
    logic             out_fire;

    // A waiting MUL resolves in the cycle of the response pulse
    assign done_now = done_q || (sel_q == FU_MUL && mul_valid_i);
    assign data_now = done_q ? data_q : mul_data_i;

    assign out_if.valid = pending_q;
    assign out_if.sel   = done_now ? FU_ALU : sel_q;
    assign out_if.rd    = rd_q;
    assign out_if.data  = data_now;
    assign out_if.done  = done_now;

    assign in_if.ready = !pending_q || (done_now && out_if.ready);

    assign in_fire  = in_if.valid && in_if.ready;
    assign out_fire = pending_q && out_if.ready;

    assign byp_o = '{pending: pending_q, rd: rd_q, done: done_now, data: data_now};

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pending_q <= 1'b0;
            sel_q     <= FU_ALU;
            done_q    <= 1'b0;
        end else if (in_fire) begin
            pending_q <= 1'b1;
            sel_q     <= in_if.done ? FU_ALU : in_if.sel;
            done_q    <= in_if.done;
        end else if (out_fire) begin
            pending_q <= 1'b0;
        end else if (pending_q && done_now) begin
            // Result held locally until downstream takes it
            sel_q  <= FU_ALU;
            done_q <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (in_fire) begin
            rd_q   <= in_if.rd;
            data_q <= in_if.data;
        end else if (pending_q && !done_q && done_now) begin
            data_q <= mul_data_i;
        end
    end

endmodule

// File: logic/int_backend.sv
`timescale 1ns/100ps

`include "backend_settings.svh"

module int_backend import backend_pkg::*; (
    input  logic               clk_i,
    input  logic               rst_ni,

    input  logic               in_valid_i,
    output logic               in_ready_o,
    input  logic [2:0]         in_op_i,
    input  logic [`REG_AW-1:0] in_rd_i,
    input  logic [`REG_AW-1:0] in_rs1_i,
    input  logic [`REG_AW-1:0] in_rs2_i,
    input  logic [`XLEN-1:0]   in_imm_i,

    output logic               commit_valid_o,
    output logic [`REG_AW-1:0] commit_rd_o,
    output logic [`XLEN-1:0]   commit_data_o
);

    // Link k feeds stage k, the last link feeds the register file
    stage_if st [`EX_DEPTH + 1] ();
    mul_if   mul_bus ();

    byp_t               byp [`EX_DEPTH];
    logic [`REG_AW-1:0] rs1_addr;
    logic [`REG_AW-1:0] rs2_addr;
    logic [`XLEN-1:0]   rs1_data;
    logic [`XLEN-1:0]   rs2_data;

    issue_unit u_issue (
        .clk_i,
        .rst_ni,
        .in_valid_i,
        .in_ready_o,
        .in_op_i    (op_e'(in_op_i)),
        .in_rd_i,
        .in_rs1_i,
        .in_rs2_i,
        .in_imm_i,
        .rs1_addr_o (rs1_addr),
        .rs2_addr_o (rs2_addr),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .byp_i      (byp),
        .mul_req    (mul_bus),
        .issue_out  (st[0])
    );

    mul_unit u_mul (
        .clk_i,
        .rst_ni,
        .bus (mul_bus)
    );

    for (genvar g = 0; g < `EX_DEPTH; g++) begin : g_stage
        ex_stage u_stage (
            .clk_i,
            .rst_ni,
            .mul_valid_i (mul_bus.resp_valid),
            .mul_data_i  (mul_bus.resp_data),
            .byp_o       (byp[g]),
            .in_if       (st[g]),
            .out_if      (st[g+1])
        );
    end

    commit_regfile u_regfile (
        .clk_i,
        .rst_ni,
        .rs1_addr_i     (rs1_addr),
        .rs2_addr_i     (rs2_addr),
        .rs1_data_o     (rs1_data),
        .rs2_data_o     (rs2_data),
        .commit_valid_o,
        .commit_rd_o,
        .commit_data_o,
        .wb_in          (st[`EX_DEPTH])
    );

endmodule

// File: logic/issue_unit.sv
`timescale 1ns/100ps

`include "backend_settings.svh"

module issue_unit import backend_pkg::*; (
    input  logic               clk_i,
    input  logic               rst_ni,

    input  logic               in_valid_i,
    output logic               in_ready_o,
    input  op_e                in_op_i,
    input  logic [`REG_AW-1:0] in_rd_i,
    input  logic [`REG_AW-1:0] in_rs1_i,
    input  logic [`REG_AW-1:0] in_rs2_i,
    input  logic [`XLEN-1:0]   in_imm_i,

    // Register file read port, data arrives one cycle later
    output logic [`REG_AW-1:0] rs1_addr_o,
    output logic [`REG_AW-1:0] rs2_addr_o,
    input  logic [`XLEN-1:0]   rs1_data_i,
    input  logic [`XLEN-1:0]   rs2_data_i,

    input  byp_t               byp_i [`EX_DEPTH],

    mul_if.req                 mul_req,
    stage_if.up                issue_out
);

    ////////////////////////////////////////
    // Operand register
    ////////////////////////////////////////

    logic               op_valid_q;
    op_e                op_q;
    logic [`REG_AW-1:0] rd_q;
    logic [`REG_AW-1:0] rs1_q;
    logic [`REG_AW-1:0] rs2_q;
    logic [`XLEN-1:0]   imm_q;

    logic accept;
    logic issue;

    assign in_ready_o = !op_valid_q || issue;
    assign accept     = in_valid_i && in_ready_o;

    // Keep reading the held sources so commits during a stall are seen
    assign rs1_addr_o = accept ? in_rs1_i : rs1_q;
    assign rs2_addr_o = accept ? in_rs2_i : rs2_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            op_valid_q <= 1'b0;
            rs1_q      <= '0;
            rs2_q      <= '0;
        end else if (accept) begin
            op_valid_q <= 1'b1;
            rs1_q      <= in_rs1_i;
            rs2_q      <= in_rs2_i;
        end else if (issue) begin
            op_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            op_q  <= in_op_i;
            rd_q  <= in_rd_i;
            imm_q <= in_imm_i;
        end
    end

    ////////////////////////////////////////
    // Forwarding and hazards
    ////////////////////////////////////////

    logic [`XLEN-1:0] rs1_val;
    logic [`XLEN-1:0] rs2_val;
    logic             rs1_haz;
    logic             rs2_haz;

    // Walk from the oldest stage to the youngest so the youngest match wins
    always_comb begin
        rs1_val = rs1_data_i;
        rs2_val = rs2_data_i;
        rs1_haz = 1'b0;
        rs2_haz = 1'b0;
        for (int k = `EX_DEPTH - 1; k >= 0; k--) begin
            if (byp_i[k].pending && byp_i[k].rd == rs1_q && rs1_q != '0) begin
                rs1_val = byp_i[k].data;
                rs1_haz = !byp_i[k].done;
            end
            if (byp_i[k].pending && byp_i[k].rd == rs2_q && rs2_q != '0) begin
                rs2_val = byp_i[k].data;
                rs2_haz = !byp_i[k].done;
            end
        end
    end

    logic is_mul;
    logic data_hazard;
    logic mul_busy;

    assign is_mul      = op_q == OP_MUL;
    // ADDI has no second register source
    assign data_hazard = rs1_haz || (rs2_haz && op_q != OP_ADDI);
    assign mul_busy    = is_mul && !mul_req.req_ready;

    ////////////////////////////////////////
    // ALU
    ////////////////////////////////////////

    logic [`XLEN-1:0] alu_res;

    always_comb begin
        unique case (op_q)
            OP_ADD:  alu_res = rs1_val + rs2_val;
            OP_SUB:  alu_res = rs1_val - rs2_val;
            OP_AND:  alu_res = rs1_val & rs2_val;
            OP_OR:   alu_res = rs1_val | rs2_val;
            OP_XOR:  alu_res = rs1_val ^ rs2_val;
            OP_ADDI: alu_res = rs1_val + imm_q;
            default: alu_res = '0;
        endcase
    end

    // Issue into stage 0
    assign issue_out.valid = op_valid_q && !data_hazard && !mul_busy;
    assign issue_out.sel   = is_mul ? FU_MUL : FU_ALU;
    assign issue_out.rd    = rd_q;
    assign issue_out.data  = alu_res;
    assign issue_out.done  = !is_mul;

    assign issue = issue_out.valid && issue_out.ready;

    // Multiplier sees the same forwarded operands
    assign mul_req.req_valid = op_valid_q && is_mul && !data_hazard && issue_out.ready;
    assign mul_req.a         = rs1_val;
    assign mul_req.b         = rs2_val;

endmodule

// File: logic/mul_unit.sv
`timescale 1ns/100ps

`include "backend_settings.svh"

module mul_unit (
    input  logic clk_i,
    input  logic rst_ni,

    mul_if.unit  bus
);

    localparam int CNT_W = $clog2(`MUL_CYCLES + 1);

    logic             busy_q;
    logic [CNT_W-1:0] cnt_q;
    logic [`XLEN-1:0] acc_q;
    logic [`XLEN-1:0] mcand_q;
    logic [`XLEN-1:0] mplier_q;

    logic accept;

    assign bus.req_ready = !busy_q;
    assign accept        = bus.req_valid && !busy_q;

    // Last partial product is added on the way out
    assign bus.resp_valid = busy_q && cnt_q == '0;
    assign bus.resp_data  = acc_q + (mplier_q[0] ? mcand_q : '0);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
        end else if (accept) begin
            busy_q <= 1'b1;
            cnt_q  <= CNT_W'(`MUL_CYCLES - 1);
        end else if (bus.resp_valid) begin
            busy_q <= 1'b0;
        end else if (busy_q) begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

    // One multiplier bit per cycle, low XLEN bits only
    always_ff @(posedge clk_i) begin
        if (accept) begin
            acc_q    <= '0;
            mcand_q  <= bus.a;
            mplier_q <= bus.b;
        end else if (busy_q && cnt_q != '0) begin
            if (mplier_q[0]) begin
                acc_q <= acc_q + mcand_q;
            end
            mcand_q  <= mcand_q << 1;
            mplier_q <= mplier_q >> 1;
        end
    end

endmodule

// File: verification/backend_tb.sv
`timescale 1ns/100ps

`include "backend_settings.svh"

module backend_tb import backend_pkg::*; ();

    localparam int CYCLE_LIMIT = 300 * (`MUL_CYCLES + 10);
    localparam int DRAIN_LIMIT = 4 * (`MUL_CYCLES + 10);

    logic               clk_i;
    logic               rst_ni;
    logic               in_valid_i;
    logic               in_ready_o;
    logic [2:0]         in_op_i;
    logic [`REG_AW-1:0] in_rd_i;
    logic [`REG_AW-1:0] in_rs1_i;
    logic [`REG_AW-1:0] in_rs2_i;
    logic [`XLEN-1:0]   in_imm_i;
    logic               commit_valid_o;
    logic [`REG_AW-1:0] commit_rd_o;
    logic [`XLEN-1:0]   commit_data_o;

    int                 cycle_cnt = 0;
    logic [31:0]        lfsr_q;
    logic [`XLEN-1:0]   shadow [`NUM_REGS];

    // Expected commits in acceptance order
    logic [`REG_AW-1:0] exp_rd_q [$];
    logic [`XLEN-1:0]   exp_data_q [$];
    logic               exp_mul_q [$];
    int                 exp_cyc_q [$];

    int_backend dut (
        .clk_i,
        .rst_ni,
        .in_valid_i,
        .in_ready_o,
        .in_op_i,
        .in_rd_i,
        .in_rs1_i,
        .in_rs2_i,
        .in_imm_i,
        .commit_valid_o,
        .commit_rd_o,
        .commit_data_o
    );

    always #2 clk_i = ~clk_i;

    ////////////////////////////////////////
    // Random source and reference model
    ////////////////////////////////////////

    // Taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_q = lfsr_step(lfsr_q);
            r = {r[30:0], lfsr_q[0]};
        end
        return r;
    endfunction

    function automatic logic [`REG_AW-1:0] pick_reg();
        logic [31:0] v;
        v = take_bits(`REG_AW);
        return v[`REG_AW-1:0];
    endfunction

    function automatic logic [`REG_AW-1:0] pick_reg_nz();
        logic [31:0] v;
        v = take_bits(`REG_AW);
        return (v[`REG_AW-1:0] == '0) ? `REG_AW'(1) : v[`REG_AW-1:0];
    endfunction

    // One of ADD SUB AND OR XOR
    function automatic op_e pick_alu_op();
        logic [31:0] v;
        v = take_bits(3);
        return op_e'(3'(v % 5));
    endfunction

    function automatic logic [`XLEN-1:0] ref_result(input op_e op,
            input logic [`XLEN-1:0] a, input logic [`XLEN-1:0] b,
            input logic [`XLEN-1:0] imm);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_ADDI: return a + imm;
            OP_MUL:  return a * b;
            default: return '0;
        endcase
    endfunction

    ////////////////////////////////////////
    // Driver tasks
    ////////////////////////////////////////

    task automatic report_mismatch(input string name, input logic [`XLEN-1:0] got,
            input logic [`XLEN-1:0] exp);
        $display("error at %0t: %s got 0x%08h expected 0x%08h", $time, name, got, exp);
    endtask

    task automatic check_idle();
        assert (commit_valid_o == 1'b0) else begin
            report_mismatch("commit_valid_o", commit_valid_o, 1'b0);
            $display("FAIL: see errors above");
            $fatal(1);
        end
        assert (in_ready_o == 1'b1) else begin
            report_mismatch("in_ready_o", in_ready_o, 1'b1);
            $display("FAIL: see errors above");
            $fatal(1);
        end
    endtask

    // Entered and left 1 ns after a rising edge
    task automatic send(input op_e op, input logic [`REG_AW-1:0] rd,
            input logic [`REG_AW-1:0] rs1, input logic [`REG_AW-1:0] rs2,
            input logic [`XLEN-1:0] imm);
        logic             acc;
        int               acc_cyc;
        logic [`XLEN-1:0] res;
        in_valid_i = 1'b1;
        in_op_i    = op;
        in_rd_i    = rd;
        in_rs1_i   = rs1;
        in_rs2_i   = rs2;
        in_imm_i   = imm;
        acc        = 1'b0;
        acc_cyc    = 0;
        while (!acc) begin
            @(negedge clk_i);
            acc     = in_ready_o;
            acc_cyc = cycle_cnt;
            @(posedge clk_i);
        end
        res = ref_result(op, shadow[rs1], shadow[rs2], imm);
        exp_rd_q.push_back(rd);
        exp_data_q.push_back(res);
        exp_mul_q.push_back(op == OP_MUL);
        exp_cyc_q.push_back(acc_cyc);
        if (rd != '0) begin
            shadow[rd] = res;
        end
        #1;
        in_valid_i = 1'b0;
    endtask

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    initial begin : stimulus
        logic [`REG_AW-1:0] rd;
        logic [`REG_AW-1:0] rd2;
        logic [`REG_AW-1:0] r_a;
        logic [`REG_AW-1:0] r_b;
        logic [`REG_AW-1:0] prev1;
        logic [`REG_AW-1:0] prev2;
        logic [`XLEN-1:0]   imm;
        op_e                op;
        clk_i      = 1'b0;
        rst_ni     = 1'b0;
        in_valid_i = 1'b0;
        in_op_i    = '0;
        in_rd_i    = '0;
        in_rs1_i   = '0;
        in_rs2_i   = '0;
        in_imm_i   = '0;
        lfsr_q     = 32'd84015;
        for (int r = 0; r < `NUM_REGS; r++) begin
            shadow[r] = '0;
        end

        // Idle outputs during and right after reset
        repeat (10) begin
            @(negedge clk_i);
            check_idle();
        end
        @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        @(negedge clk_i);
        check_idle();
        @(posedge clk_i);
        #1;

        // Load every register, then random register ops
        for (int r = 1; r < `NUM_REGS; r++) begin
            imm = take_bits(`XLEN);
            send(OP_ADDI, `REG_AW'(r), '0, '0, imm);
        end
        for (int i = 0; i < 100; i++) begin
            op  = pick_alu_op();
            rd  = pick_reg();
            r_a = pick_reg();
            r_b = pick_reg();
            send(op, rd, r_a, r_b, '0);
        end

        // Dependent chains hit forwarding from each stage
        prev1 = `REG_AW'(3);
        prev2 = `REG_AW'(7);
        for (int i = 0; i < 40; i++) begin
            op  = (i % 4 == 3) ? OP_ADDI : pick_alu_op();
            rd  = pick_reg_nz();
            imm = take_bits(`XLEN);
            send(op, rd, prev1, prev2, imm);
            prev2 = prev1;
            prev1 = rd;
        end

        // MUL followed at once by dependent and independent ops
        for (int g = 0; g < 6; g++) begin
            rd  = pick_reg_nz();
            r_a = pick_reg_nz();
            r_b = pick_reg_nz();
            send(OP_MUL, rd, r_a, r_b, '0);
            rd2 = pick_reg_nz();
            send(OP_ADD, rd2, rd, r_a, '0);
            send(OP_XOR, pick_reg_nz(), r_a ^ `REG_AW'(8), r_b, '0);
            send(OP_SUB, pick_reg_nz(), rd2, rd, '0);
        end

        // Back to back MULs, every other pair dependent
        for (int g = 0; g < 5; g++) begin
            rd  = (g == 4) ? '0 : pick_reg_nz();
            r_a = pick_reg_nz();
            r_b = pick_reg_nz();
            send(OP_MUL, rd, r_a, r_b, '0);
            send(OP_MUL, pick_reg_nz(), (g % 2 == 1) ? rd : r_b, r_a, '0);
        end

        // Writes to register 0 commit but never stick
        for (int g = 0; g < 5; g++) begin
            imm = take_bits(`XLEN);
            r_a = pick_reg();
            send(OP_ADDI, '0, r_a, '0, imm);
            send(OP_ADD, pick_reg_nz(), '0, '0, '0);
            r_b = pick_reg_nz();
            send(OP_OR, pick_reg_nz(), '0, r_b, '0);
        end

        // Outstanding commits drain within a few MUL latencies
        for (int w = 0; w < DRAIN_LIMIT && exp_rd_q.size() != 0; w++) begin
            @(posedge clk_i);
        end
        repeat (10) @(posedge clk_i);

        if (exp_rd_q.size() != 0) begin
            $display("error at %0t: %0d commits never arrived", $time, exp_rd_q.size());
            $display("FAIL: see errors above");
            $fatal(1);
        end else begin
            $display("PASS: all tests");
            $finish;
        end
    end

    ////////////////////////////////////////
    // Compare and timeout
    ////////////////////////////////////////

    always @(negedge clk_i) begin : compare
        logic [`REG_AW-1:0] e_rd;
        logic [`XLEN-1:0]   e_data;
        logic               e_mul;
        int                 e_cyc;
        if (rst_ni && commit_valid_o) begin
            if (exp_rd_q.size() == 0) begin
                $display("error at %0t: commit seen with no instruction outstanding", $time);
                $display("FAIL: see errors above");
                $fatal(1);
            end else begin
                e_rd   = exp_rd_q.pop_front();
                e_data = exp_data_q.pop_front();
                e_mul  = exp_mul_q.pop_front();
                e_cyc  = exp_cyc_q.pop_front();
                assert (commit_rd_o == e_rd) else begin
                    report_mismatch("commit_rd_o", commit_rd_o, e_rd);
                    $display("FAIL: see errors above");
                    $fatal(1);
                end
                assert (commit_data_o == e_data) else begin
                    report_mismatch("commit_data_o", commit_data_o, e_data);
                    $display("FAIL: see errors above");
                    $fatal(1);
                end
                assert (!e_mul || (cycle_cnt - e_cyc) >= `MUL_CYCLES) else begin
                    $display("error at %0t: MUL committed %0d cycles after acceptance",
                             $time, cycle_cnt - e_cyc);
                    $display("FAIL: see errors above");
                    $fatal(1);
                end
            end
        end
    end

    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt > CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("FAIL: see errors above");
            $fatal(1);
        end
    end

endmodule
